// File: Makefile
# Verilator build and run of the core testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module coreTb -f verilog.f -Mdir obj_dir
	out="$$(./obj_dir/VcoreTb)"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: dv/coreTb.sv
`default_nettype none

module coreTb import coreTypes::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////
  // Run length
  //////////////////////////////

  localparam int resetCycles = 16;
  localparam int quietCycles = 20;
  localparam int numRawWords = 80;
  localparam int numStallWords = 2;
  localparam int stallCycles = 40;
  localparam int spikeRunCycles = 1600;
  localparam int spikeRawEvery = 64;
  localparam int drainCycles = 2000;
  // Stall on and off, four tags, four periods, unit length on and off
  localparam int numCfgWords = 12;
  localparam int numHostWords = numRawWords + numStallWords + numCfgWords
    + spikeRunCycles / spikeRawEvery;
  localparam int limitCycles = numHostWords * 40 + stallCycles + resetCycles
    + quietCycles + spikeRunCycles + drainCycles;

  logic clk;
  logic rstN;
  pcWordT pcIn;
  logic pcInValid;
  logic pcInReady;
  bdWordT bdOut;
  logic bdOutValid;
  logic bdOutReady;

  // Model register file and timing state
  cfgT mCfg;
  int phase;
  logic pulse;
  logic stallPrev;
  logic [numGens-1:0] genFresh;
  int countdown [numGens];
  int fires [numGens];
  int recvSum [numGens];
  int maxCount;
  logic [payloadWidth-1:0] rawQ [$];

  logic idleCheck;
  int readyMode;
  int stretchLeft;

  core core_i (
    .clk(clk),
    .rstN(rstN),
    .pcIn(pcIn),
    .pcInValid(pcInValid),
    .pcInReady(pcInReady),
    .bdOut(bdOut),
    .bdOutValid(bdOutValid),
    .bdOutReady(bdOutReady)
  );

  always #5 clk = !clk;

  // Ends a hung run
  initial begin
    #(limitCycles * 10);
    $display("Run timed out after %0d cycles", limitCycles);
    $display("Test failures found");
    $fatal(1);
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic int genOfTag(input logic [tagWidth-1:0] tag);
    for (int i = 0; i < numGens; i++) begin
      if (mCfg.tags[i] == tag) return i;
    end
    return -1;
  endfunction

  // Raw words leave in host order with header 0
  task automatic checkRawWord(input bdWordT got);
    bdWordT exp;
    if (rawQ.size() == 0) begin
      failNow("Raw word came out with none expected");
    end else begin
      exp.header = 1'b0;
      exp.body = rawQ.pop_front();
      if (got !== exp) begin
        failNow($sformatf("FAIL bdOut got %h expected %h", got, exp));
      end
    end
  endtask

  task automatic countSpike(input spikeT s);
    int idx;
    idx = genOfTag(s.tag);
    if (idx < 0) begin
      failNow($sformatf("Spike arrived with unknown tag %h", s.tag));
    end else if (s.count == '0) begin
      failNow("Spike word carried a zero count");
    end else if (s.count == '1) begin
      failNow("Spike count reached saturation");
    end else begin
      recvSum[idx] += int'(s.count);
      if (int'(s.count) > maxCount) maxCount = int'(s.count);
      // Delivery can never run ahead of firing
      if (recvSum[idx] > fires[idx]) begin
        failNow($sformatf("More spikes delivered for tag %h than fired", s.tag));
      end
    end
  endtask

  task automatic checkSpikeTotal(input logic [tagWidth-1:0] tag, input int got, input int exp);
    if (got != exp) begin
      failNow($sformatf("FAIL spikeCount tag %h got %h expected %h", tag, got, exp));
    end
  endtask

  //////////////////////////////
  // Model
  //////////////////////////////

  // Advance one clock edge
  task automatic stepModel();
    logic pulseNext;
    pulseNext = 1'b0;
    if (mCfg.unitLen != '0 && phase >= 1) begin
      // Unit ends every unitLen cycles after a change, strobe one cycle later
      pulseNext = (phase % int'(mCfg.unitLen)) == 0;
    end
    for (int i = 0; i < numGens; i++) begin
      if (genFresh[i]) begin
        countdown[i] = int'(mCfg.periods[i]);
      end else if (pulse && mCfg.periods[i] != '0) begin
        countdown[i]--;
        if (countdown[i] == 0) begin
          fires[i]++;
          countdown[i] = int'(mCfg.periods[i]);
        end
      end
    end
    genFresh = '0;
    pulse = pulseNext;
    phase++;
    stallPrev = mCfg.stall;
  endtask

  // Accepted host word, takes effect after the edge
  task automatic acceptHostWord(input pcWordT w);
    int idx;
    if (w.cfgWord.code == codeBd) begin
      rawQ.push_back(w.bdWord.data);
    end else if (w.cfgWord.code == codeCfg && int'(w.cfgWord.addr) < numRegs) begin
      if (w.cfgWord.addr == regUnitLen) begin
        if (w.cfgWord.value != mCfg.unitLen) phase = 0;
        mCfg.unitLen = w.cfgWord.value;
      end else if (w.cfgWord.addr == regStall) begin
        mCfg.stall = w.cfgWord.value[0];
      end else if (w.cfgWord.addr < regTagBase) begin
        idx = int'(w.cfgWord.addr - regPeriodBase);
        if (w.cfgWord.value != mCfg.periods[idx]) genFresh[idx] = 1'b1;
        mCfg.periods[idx] = w.cfgWord.value;
      end else begin
        idx = int'(w.cfgWord.addr - regTagBase);
        if (w.cfgWord.value[tagWidth-1:0] != mCfg.tags[idx]) genFresh[idx] = 1'b1;
        mCfg.tags[idx] = w.cfgWord.value[tagWidth-1:0];
      end
    end
  endtask

  // Sampled mid cycle where all inputs and outputs are settled
  always @(negedge clk) begin
    if (rstN) begin
      if (idleCheck && bdOutValid) failNow("bdOutValid rose before any configuration");
      if (bdOutValid && bdOutReady) begin
        // Stall visible for two cycles blocks the output
        if (mCfg.stall && stallPrev) failNow("Output transfer while stall was set");
        if (bdOut.header) begin
          countSpike(spikeT'(bdOut.body));
        end else begin
          checkRawWord(bdOut);
        end
      end
      stepModel();
      if (pcInValid && pcInReady) acceptHostWord(pcIn);
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Chip side ready: always, random, or long stretches
  always @(posedge clk) begin
    #1;
    if (readyMode == 0) begin
      bdOutReady = 1'b1;
    end else if (readyMode == 1) begin
      bdOutReady = 1'($urandom_range(0, 1));
    end else if (stretchLeft == 0) begin
      bdOutReady = !bdOutReady;
      stretchLeft = bdOutReady ? $urandom_range(1, 4) : $urandom_range(40, 80);
    end else begin
      stretchLeft--;
    end
  end

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic sendWord(input pcWordT w);
    logic taken;
    pcIn = w;
    pcInValid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = pcInReady;
    end
    @(posedge clk);
    #1;
    pcInValid = 1'b0;
  endtask

  task automatic writeReg(input logic [7:0] addr, input logic [15:0] value);
    pcWordT w;
    w.cfgWord.code = codeCfg;
    w.cfgWord.addr = addr;
    w.cfgWord.value = value;
    sendWord(w);
  endtask

  // Pad bits stay random
  task automatic sendRaw(input logic [payloadWidth-1:0] data);
    pcWordT w;
    w = pcWordT'($urandom());
    w.bdWord.code = codeBd;
    w.bdWord.data = data;
    sendWord(w);
  endtask

  task automatic waitRawDrained();
    while (rawQ.size() != 0) nextCycle();
  endtask

  function automatic logic allDelivered();
    if (rawQ.size() != 0) return 1'b0;
    for (int i = 0; i < numGens; i++) begin
      if (recvSum[i] != fires[i]) return 1'b0;
    end
    return 1'b1;
  endfunction

  // Raw words mixed with junk codes and writes past the map
  task automatic runRawTraffic();
    pcWordT w;
    int kind;
    readyMode = 1;
    for (int k = 0; k < numRawWords; k++) begin
      kind = $urandom_range(0, 7);
      w = pcWordT'($urandom());
      if (kind < 6) begin
        w.bdWord.code = codeBd;
      end else if (kind == 6) begin
        // 256 wraps to code 0
        w.cfgWord.code = 8'($urandom_range(3, 256));
      end else begin
        w.cfgWord.code = codeCfg;
        w.cfgWord.addr = 8'($urandom_range(numRegs, 255));
      end
      sendWord(w);
    end
    waitRawDrained();
  endtask

  // FIFO fills while stalled, host side stays open
  task automatic runStallTest();
    readyMode = 0;
    writeReg(regStall, 16'd1);
    for (int k = 0; k < numStallWords; k++) begin
      sendRaw(payloadWidth'($urandom()));
    end
    repeat (stallCycles) nextCycle();
    writeReg(regStall, 16'd0);
    waitRawDrained();
  endtask

  task automatic runSpikeTest();
    // Low three bits keep the tags distinct
    for (int i = 0; i < numGens; i++) begin
      writeReg(regTagBase + 8'(i), 16'({8'($urandom_range(0, 255)), 3'(i)}));
    end
    for (int i = 0; i < numGens; i++) begin
      writeReg(regPeriodBase + 8'(i), 16'($urandom_range(1, 4)));
    end
    writeReg(regUnitLen, 16'($urandom_range(2, 4)));
    for (int c = 0; c < spikeRunCycles; c++) begin
      readyMode = (c < spikeRunCycles / 2) ? 2 : 1;
      if (c % spikeRawEvery == 0) begin
        sendRaw(payloadWidth'($urandom()));
      end else begin
        nextCycle();
      end
    end
    // Disable, then drain for a bounded time
    writeReg(regUnitLen, 16'd0);
    readyMode = 0;
    repeat (4) nextCycle();
    for (int c = 0; c < drainCycles && !allDelivered(); c++) begin
      nextCycle();
    end
    repeat (50) nextCycle();
    for (int i = 0; i < numGens; i++) begin
      if (fires[i] == 0) failNow($sformatf("Generator %0d never fired", i));
      checkSpikeTotal(mCfg.tags[i], recvSum[i], fires[i]);
    end
    if (maxCount < 2) failNow("Spikes never collapsed under back-pressure");
  endtask

  initial begin
    void'($urandom(32'ha541_0eba));
    clk = 1'b0;
    rstN = 1'b0;
    pcIn = '0;
    pcInValid = 1'b0;
    bdOutReady = 1'b0;
    mCfg = '0;
    phase = 0;
    pulse = 1'b0;
    stallPrev = 1'b0;
    genFresh = '0;
    for (int i = 0; i < numGens; i++) begin
      countdown[i] = 0;
      fires[i] = 0;
      recvSum[i] = 0;
    end
    maxCount = 0;
    idleCheck = 1'b0;
    readyMode = 0;
    stretchLeft = 0;
    repeat (resetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;
    // Nothing configured, nothing may come out
    idleCheck = 1'b1;
    repeat (quietCycles) nextCycle();
    idleCheck = 1'b0;
    runRawTraffic();
    runStallTest();
    runSpikeTest();
    if (rawQ.size() != 0) begin
      $display("Raw words still missing at the end of the run");
      $display("Test failures found");
      $fatal(1);
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: logic/bdOutputStage.sv
`default_nettype none

module bdOutputStage import coreTypes::*; (
  input wire logic clk,
  input wire logic rstN,
  input wire mergedWordT mergedWord,
  input wire logic mergedValid,
  output logic mergedReady,
  input wire logic stall,
  output bdWordT bdOut,
  output logic bdOutValid,
  input wire logic bdOutReady
);

  bdWordT fifoMem [fifoDepth];
  bdWordT encoded;
  logic wrPtr;
  logic rdPtr;
  logic [1:0] fill;
  logic stallQ;
  logic push;
  logic pop;

  // Spikes get header 1, raw words header 0
  assign encoded.header = mergedWord.isSpike;
  assign encoded.body = mergedWord.payload;

  //////////////////////////////
  // Two entry FIFO
  //////////////////////////////

  assign mergedReady = (fill != 2'(fifoDepth));
  assign push = mergedValid && mergedReady;
  assign pop = bdOutValid && bdOutReady;

  always_ff @(posedge clk) begin
    if (push) begin
      fifoMem[wrPtr] <= encoded;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      fill <= '0;
      stallQ <= 1'b0;
    end else begin
      stallQ <= stall;
      if (push) wrPtr <= !wrPtr;
      if (pop) rdPtr <= !rdPtr;
      fill <= fill + 2'(push) - 2'(pop);
    end
  end

  // Head held while stalled
  assign bdOut = fifoMem[rdPtr];
  assign bdOutValid = (fill != '0) && !stallQ;

endmodule

`default_nettype wire

// File: logic/bdTagMerge.sv
`default_nettype none

module bdTagMerge import coreTypes::*; (
  input wire logic clk,
  input wire logic rstN,
  input wire [payloadWidth-1:0] rawWord,
  input wire logic rawValid,
  output logic rawReady,
  input wire spikeT [numGens-1:0] spike,
  input wire [numGens-1:0] spikeValid,
  output logic [numGens-1:0] spikeReady,
  output mergedWordT mergedWord,
  output logic mergedValid,
  input wire logic mergedReady
);

  logic [genIdxWidth-1:0] ptr;
  logic [genIdxWidth-1:0] winner;
  logic [genIdxWidth-1:0] candIdx;
  logic found;
  logic spikeGrant;
  logic spikeXfer;

  //////////////////////////////
  // Round robin search
  //////////////////////////////

  // First valid generator starting at the pointer
  always_comb begin
    found = 1'b0;
    winner = ptr;
    candIdx = ptr;
    for (int k = 0; k < numGens; k++) begin
      candIdx = genIdxWidth'((int'(ptr) + k) % numGens);
      if (!found && spikeValid[candIdx]) begin
        found = 1'b1;
        winner = candIdx;
      end
    end
  end

  //////////////////////////////
  // Grant and output mux
  //////////////////////////////

  // Raw words always win
  assign spikeGrant = !rawValid && found;

  assign mergedValid = rawValid || found;
  assign rawReady = rawValid && mergedReady;

  always_comb begin
    if (rawValid) begin
      mergedWord.isSpike = 1'b0;
      mergedWord.payload = rawWord;
    end else begin
      mergedWord.isSpike = 1'b1;
      mergedWord.payload = spike[winner];
    end
  end

  // Ready only towards the winner
  always_comb begin
    spikeReady = '0;
    if (spikeGrant && mergedReady) begin
      spikeReady[winner] = 1'b1;
    end
  end

  assign spikeXfer = spikeGrant && mergedReady;

  //////////////////////////////
  // Pointer
  //////////////////////////////

  // Next search starts past the last winner
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ptr <= '0;
    end else if (spikeXfer) begin
      ptr <= genIdxWidth'((int'(winner) + 1) % numGens);
    end
  end

endmodule

`default_nettype wire

// File: logic/core.sv
`default_nettype none

module core import coreTypes::*; (
  input wire logic clk,
  input wire logic rstN,
  input wire pcWordT pcIn,
  input wire logic pcInValid,
  output logic pcInReady,
  output bdWordT bdOut,
  output logic bdOutValid,
  input wire logic bdOutReady
);

  //////////////////////////////
  // Internal links
  //////////////////////////////

  // Plain config registers
  cfgT cfg;
  logic unitPulse;

  // Raw words into the merge
  logic [payloadWidth-1:0] rawWord;
  logic rawValid;
  logic rawReady;

  // Generator spikes
  spikeT [numGens-1:0] spike;
  logic [numGens-1:0] spikeValid;
  logic [numGens-1:0] spikeReady;

  // Merged stream
  mergedWordT mergedWord;
  logic mergedValid;
  logic mergedReady;

  //////////////////////////////
  // Config and timing
  //////////////////////////////

  pcConfigParser parser_i (
    .clk(clk),
    .rstN(rstN),
    .pcIn(pcIn),
    .pcInValid(pcInValid),
    .pcInReady(pcInReady),
    .cfg(cfg),
    .rawWord(rawWord),
    .rawValid(rawValid),
    .rawReady(rawReady)
  );

  timeUnitMgr timeMgr_i (
    .clk(clk),
    .rstN(rstN),
    .unitLen(cfg.unitLen),
    .unitPulse(unitPulse)
  );

  //////////////////////////////
  // Host to chip datapath
  //////////////////////////////

  // One generator per period and tag pair
  for (genvar i = 0; i < numGens; i++) begin : genArray
    spikeGenerator gen_i (
      .clk(clk),
      .rstN(rstN),
      .unitPulse(unitPulse),
      .period(cfg.periods[i]),
      .tag(cfg.tags[i]),
      .spike(spike[i]),
      .spikeValid(spikeValid[i]),
      .spikeReady(spikeReady[i])
    );
  end

  bdTagMerge merge_i (
    .clk(clk),
    .rstN(rstN),
    .rawWord(rawWord),
    .rawValid(rawValid),
    .rawReady(rawReady),
    .spike(spike),
    .spikeValid(spikeValid),
    .spikeReady(spikeReady),
    .mergedWord(mergedWord),
    .mergedValid(mergedValid),
    .mergedReady(mergedReady)
  );

  // Stall flag gates the chip side
  bdOutputStage outStage_i (
    .clk(clk),
    .rstN(rstN),
    .mergedWord(mergedWord),
    .mergedValid(mergedValid),
    .mergedReady(mergedReady),
    .stall(cfg.stall),
    .bdOut(bdOut),
    .bdOutValid(bdOutValid),
    .bdOutReady(bdOutReady)
  );

endmodule

`default_nettype wire

// File: logic/coreTypes.sv
`default_nettype none

package coreTypes;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Spike generator array
  localparam int numGens = 4;
  localparam int genIdxWidth = $clog2(numGens);

  // Spike word fields
  localparam int tagWidth = 11;
  localparam int countWidth = 9;
  localparam int payloadWidth = tagWidth + countWidth;

  // Timing fields, in time units and clock cycles
  localparam int periodWidth = 16;
  localparam int unitWidth = 16;

  // Output buffer entries
  localparam int fifoDepth = 2;

  //////////////////////////////
  // Host protocol
  //////////////////////////////

  // Code byte values
  localparam logic [7:0] codeCfg = 8'h01;
  localparam logic [7:0] codeBd = 8'h02;

  // Register map
  localparam logic [7:0] regUnitLen = 8'd0;
  localparam logic [7:0] regStall = 8'd1;
  localparam logic [7:0] regPeriodBase = 8'd2;
  localparam logic [7:0] regTagBase = regPeriodBase + 8'(numGens);
  localparam int numRegs = int'(regTagBase) + numGens;

  // Config write view of a host word
  typedef struct packed {
    logic [7:0] code;
    logic [7:0] addr;
    logic [15:0] value;
  } cfgWordT;

  // Raw chip word view of a host word
  typedef struct packed {
    logic [7:0] code;
    logic [3:0] pad;
    logic [payloadWidth-1:0] data;
  } bdHostWordT;

  // Same 32 bits, decoded by code byte
  typedef union packed {
    cfgWordT cfgWord;
    bdHostWordT bdWord;
  } pcWordT;

  //////////////////////////////
  // Datapath words
  //////////////////////////////

  typedef struct packed {
    logic [tagWidth-1:0] tag;
    logic [countWidth-1:0] count;
  } spikeT;

  typedef struct packed {
    logic isSpike;
    logic [payloadWidth-1:0] payload;
  } mergedWordT;

  // Header 1 marks a spike body
  typedef struct packed {
    logic header;
    logic [payloadWidth-1:0] body;
  } bdWordT;

  // Decoded register file
  typedef struct packed {
    logic [unitWidth-1:0] unitLen;
    logic stall;
    logic [numGens-1:0][periodWidth-1:0] periods;
    logic [numGens-1:0][tagWidth-1:0] tags;
  } cfgT;

endpackage

`default_nettype wire

// File: logic/pcConfigParser.sv
`default_nettype none

module pcConfigParser import coreTypes::*; (
  input wire logic clk,
  input wire logic rstN,
  input wire pcWordT pcIn,
  input wire logic pcInValid,
  output logic pcInReady,
  output cfgT cfg,
  output logic [payloadWidth-1:0] rawWord,
  output logic rawValid,
  input wire logic rawReady
);

  //////////////////////////////
  // Decode
  //////////////////////////////

  logic [7:0] code;
  cfgWordT cfgView;
  logic inXfer;
  logic cfgWrite;
  logic rawLoad;
  logic [genIdxWidth-1:0] periodIdx;
  logic [genIdxWidth-1:0] tagIdx;

  // Code byte sits at the same place in both views
  assign code = pcIn.cfgWord.code;
  assign cfgView = pcIn.cfgWord;

  // Raw slot empty or emptying this cycle
  assign pcInReady = !rawValid || rawReady;
  assign inXfer = pcInValid && pcInReady;

  // Writes past the map fall through unused
  assign cfgWrite = inXfer && (code == codeCfg) && (int'(cfgView.addr) < numRegs);
  assign rawLoad = inXfer && (code == codeBd);

  // Generator index within each register bank
  assign periodIdx = genIdxWidth'(cfgView.addr - regPeriodBase);
  assign tagIdx = genIdxWidth'(cfgView.addr - regTagBase);

  //////////////////////////////
  // Register file
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      cfg <= '0;
    end else if (cfgWrite) begin
      if (cfgView.addr == regUnitLen) begin
        cfg.unitLen <= cfgView.value;
      end else if (cfgView.addr == regStall) begin
        // Only bit 0 is meaningful
        cfg.stall <= cfgView.value[0];
      end else if (cfgView.addr < regTagBase) begin
        cfg.periods[periodIdx] <= cfgView.value;
      end else begin
        cfg.tags[tagIdx] <= cfgView.value[tagWidth-1:0];
      end
    end
  end

  //////////////////////////////
  // Raw word slot
  //////////////////////////////

  // Reload on same-cycle drain keeps valid high
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rawValid <= 1'b0;
    end else if (rawLoad) begin
      rawValid <= 1'b1;
    end else if (rawReady) begin
      rawValid <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (rawLoad) begin
      rawWord <= pcIn.bdWord.data;
    end
  end

endmodule

`default_nettype wire

// File: logic/spikeGenerator.sv
`default_nettype none

module spikeGenerator import coreTypes::*; (
  input wire logic clk,
  input wire logic rstN,
  input wire logic unitPulse,
  input wire [periodWidth-1:0] period,
  input wire [tagWidth-1:0] tag,
  output spikeT spike,
  output logic spikeValid,
  input wire logic spikeReady
);

  logic [periodWidth-1:0] countdown;
  logic [periodWidth-1:0] lastPeriod;
  logic [tagWidth-1:0] lastTag;
  logic [countWidth-1:0] pending;
  logic [countWidth-1:0] pendingBase;
  logic cfgChanged;
  logic fire;
  logic spikeXfer;

  //////////////////////////////
  // Countdown
  //////////////////////////////

  // Any period or tag write reloads
  assign cfgChanged = (period != lastPeriod) || (tag != lastTag);

  // Countdown at 1 hits zero on this pulse
  assign fire = !cfgChanged && unitPulse && (period != '0) && (countdown <= 1);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      countdown <= '0;
      lastPeriod <= '0;
      lastTag <= '0;
    end else begin
      lastPeriod <= period;
      lastTag <= tag;
      if (cfgChanged || fire) begin
        countdown <= period;
      end else if (unitPulse && (period != '0)) begin
        countdown <= countdown - 1'b1;
      end
    end
  end

  //////////////////////////////
  // Pending spikes
  //////////////////////////////

  assign spikeXfer = spikeValid && spikeReady;

  // Delivered count leaves the pending total
  assign pendingBase = spikeXfer ? '0 : pending;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pending <= '0;
    end else if (fire && (pendingBase != '1)) begin
      // Saturates at all ones
      pending <= pendingBase + 1'b1;
    end else begin
      pending <= pendingBase;
    end
  end

  // Offered until the merge takes it
  assign spikeValid = (pending != '0);
  assign spike.tag = tag;
  assign spike.count = pending;

endmodule

`default_nettype wire

// File: logic/timeUnitMgr.sv
`default_nettype none

module timeUnitMgr import coreTypes::*; (
  input wire logic clk,
  input wire logic rstN,
  input wire [unitWidth-1:0] unitLen,
  output logic unitPulse
);

  logic [unitWidth-1:0] lastLen;
  logic [unitWidth-1:0] cycleCnt;
  logic [unitWidth-1:0] cntNext;
  logic lenChanged;
  logic unitEnd;

  // New length restarts the count
  assign lenChanged = (unitLen != lastLen);
  assign cntNext = cycleCnt + 1'b1;

  // Last cycle of a unit; zero length never ends
  assign unitEnd = !lenChanged && (unitLen != '0) && (cntNext == unitLen);

  //////////////////////////////
  // Cycle counter
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      lastLen <= '0;
      cycleCnt <= '0;
      unitPulse <= 1'b0;
    end else begin
      lastLen <= unitLen;
      // One cycle strobe per unit
      unitPulse <= unitEnd;
      if (lenChanged || (unitLen == '0) || unitEnd) begin
        cycleCnt <= '0;
      end else begin
        cycleCnt <= cntNext;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
logic/coreTypes.sv
logic/pcConfigParser.sv
logic/timeUnitMgr.sv
logic/spikeGenerator.sv
logic/bdTagMerge.sv
logic/bdOutputStage.sv
logic/core.sv
dv/coreTb.sv
